//--- list.f
+incdir+rtl
rtl/mcr3_input_pkg.sv
rtl/player_ctrl_if.sv
rtl/ctrl_sampler.sv
rtl/wheel_spinner.sv
rtl/cabinet_state.sv
rtl/input_port_map.sv
rtl/mcr3_input_top.sv
dv/tb_mcr3_input.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_mcr3_input
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/tb_mcr3_input.sv
`include "mcr3_consts.svh"

module tb_mcr3_input
	import mcr3_input_pkg::*;
	();

	localparam int CLK_PERIOD = 8;
	localparam int PHASE_CYCLES = 200;
	localparam int NUM_PHASES = 7;
	localparam int TIMEOUT = NUM_PHASES * PHASE_CYCLES * CLK_PERIOD + 50 * CLK_PERIOD;

	logic clk_sys;
	logic reset;
	game_t game;
	logic [3:0] dip;
	logic service;
	logic [1:0] snd_stat;
	logic vsync;
	player_array_t players;
	cabinet_ctrl_t cabinet;
	logic [7:0] cpu_out6;
	logic [4:0][`MCR3_PORT_W-1:0] dut_ports;
	sound_board_t sound_board;
	logic mono_board;

	// Model of the cabinet state
	logic [2:0] m_gear;
	logic [`MCR3_NUM_PLAYERS-1:0][`MCR3_WHEEL_W-1:0] m_wheel;
	logic m_dsel;
	player_array_t m_prev_players;
	logic m_prev_vsync;

	// Delay lines, index 0 is the newest drive
	game_t h_game [4];
	logic [3:0] h_dip [4];
	logic h_service [4];
	logic [1:0] h_snd [4];
	player_array_t h_players [4];
	cabinet_ctrl_t h_cabinet [4];
	logic [2:0] h_gear [4];
	logic [`MCR3_NUM_PLAYERS-1:0][`MCR3_WHEEL_W-1:0] h_wheel [4];
	logic h_dsel [4];

	int check_count;
	int port_errors;
	int board_errors;

	mcr3_input_top UUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game        (game),
		.dip         (dip),
		.service     (service),
		.snd_stat    (snd_stat),
		.vsync       (vsync),
		.players     (players),
		.cabinet     (cabinet),
		.cpu_out6    (cpu_out6),
		.in0         (dut_ports[0]),
		.in1         (dut_ports[1]),
		.in2         (dut_ports[2]),
		.in3         (dut_ports[3]),
		.in4         (dut_ports[4]),
		.sound_board (sound_board),
		.mono_board  (mono_board)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	// ==============================
	// Reference mapping
	// ==============================

	// Rampage stick, from bit 0 up, right, down, left, fire_a, fire_b
	function automatic logic [7:0] stick_rampage(input player_ctrl_t pc);
		return {2'b00, pc.fire_b, pc.fire_a, pc.left, pc.down, pc.right, pc.up};
	endfunction

	// Tapper stick, from bit 0 right, left, down, up, fire_a, fire_b
	function automatic logic [7:0] stick_tapper(input player_ctrl_t pc);
		return {2'b00, pc.fire_b, pc.fire_a, pc.up, pc.down, pc.left, pc.right};
	endfunction

	// Power Drive nibble per driver
	function automatic logic [3:0] shifter(input player_ctrl_t pc, input logic g);
		return {pc.fire_b, pc.fire_a, g, pc.fire_c};
	endfunction

	function automatic logic [4:0][7:0] expected_ports();
		logic [4:0][7:0] w;
		player_array_t pl;
		cabinet_ctrl_t cb;
		logic [3:0] dp;
		logic svc;
		pl = h_players[3];
		cb = h_cabinet[3];
		dp = h_dip[1];
		svc = h_service[1];
		w = '0;
		case (h_game[1])
			`MCR3_GAME_RAMPAGE: begin
				w[0] = {2'b00, svc, 3'b000, cb.coin2, cb.coin1};
				w[1] = stick_rampage(pl[0]);
				w[2] = stick_rampage(pl[1]);
				w[3] = {dp[3], 4'b0000, dp[2:0]};
				w[4] = stick_rampage(pl[2]);
			end
			`MCR3_GAME_POWERDRV: begin
				w[0] = {2'b00, svc, 2'b00, cb.coin3, cb.coin2, cb.coin1};
				w[1] = {shifter(pl[1], h_gear[3][1]), shifter(pl[0], h_gear[3][0])};
				w[2] = {h_snd[1][0], 3'b000, shifter(pl[2], h_gear[3][2])};
				w[3] = {dp, 4'b0000};
			end
			`MCR3_GAME_DEMODERB: begin
				w[0] = {2'b00, svc, 1'b0, cb.start2, cb.start1, cb.coin2, cb.coin1};
				w[1] = {(h_dsel[2] ? h_wheel[3][2] : h_wheel[3][0]), pl[0].fire_b, pl[0].fire_a};
				w[2] = {(h_dsel[2] ? h_wheel[3][3] : h_wheel[3][1]), pl[1].fire_b, pl[1].fire_a};
				w[3] = {4'b0000, dp};
				w[4] = {pl[3].fire_b, pl[3].fire_a, pl[2].fire_b, pl[2].fire_a,
					cb.start4, cb.start3, cb.coin4, cb.coin3};
			end
			`MCR3_GAME_TIMBER, `MCR3_GAME_TAPPER: begin
				w[0] = {svc, 3'b000, cb.start2, cb.start1, cb.coin2, cb.coin1};
				w[1] = stick_tapper(pl[0]);
				w[2] = stick_tapper(pl[1]);
				w[3] = {1'b0, dp[1], 3'b000, dp[2], 2'b00};
			end
			default: w = '0;
		endcase
		return ~w;
	endfunction

	function automatic game_t unknown_game(input logic [31:0] r);
		game_t g;
		g = r[6:0];
		if (g inside {`MCR3_GAME_RAMPAGE, `MCR3_GAME_POWERDRV, `MCR3_GAME_DEMODERB,
			`MCR3_GAME_TIMBER, `MCR3_GAME_TAPPER}) begin
			g = g | 7'h08;
		end
		return g;
	endfunction

	// ==============================
	// Stimulus and model update
	// ==============================

	task automatic apply_inputs(input game_t g, input player_array_t pl, input cabinet_ctrl_t cb,
		input logic [3:0] dp, input logic svc, input logic [1:0] ss, input logic vs,
		input logic [7:0] c6);
		player_array_t rise;
		game <= g;
		players <= pl;
		cabinet <= cb;
		dip <= dp;
		service <= svc;
		snd_stat <= ss;
		vsync <= vs;
		cpu_out6 <= c6;
		rise = pl & ~m_prev_players;
		for (int n = 0; n < 3; n++) begin
			if (rise[n].fire_d) begin
				m_gear[n] = ~m_gear[n];
			end
		end
		// One wheel step per frame edge
		if (vs && !m_prev_vsync) begin
			for (int p = 0; p < `MCR3_NUM_PLAYERS; p++) begin
				if (pl[p].right && !pl[p].left) begin
					m_wheel[p] = m_wheel[p] + 6'd1;
				end else if (pl[p].left && !pl[p].right) begin
					m_wheel[p] = m_wheel[p] - 6'd1;
				end
			end
		end
		if (c6[7]) begin
			m_dsel = 1'b0;
		end else if (c6[6]) begin
			m_dsel = 1'b1;
		end
		m_prev_players = pl;
		m_prev_vsync = vs;
		for (int i = 3; i > 0; i--) begin
			h_game[i] = h_game[i - 1];
			h_dip[i] = h_dip[i - 1];
			h_service[i] = h_service[i - 1];
			h_snd[i] = h_snd[i - 1];
			h_players[i] = h_players[i - 1];
			h_cabinet[i] = h_cabinet[i - 1];
			h_gear[i] = h_gear[i - 1];
			h_wheel[i] = h_wheel[i - 1];
			h_dsel[i] = h_dsel[i - 1];
		end
		h_game[0] = g;
		h_dip[0] = dp;
		h_service[0] = svc;
		h_snd[0] = ss;
		h_players[0] = pl;
		h_cabinet[0] = cb;
		h_gear[0] = m_gear;
		h_wheel[0] = m_wheel;
		h_dsel[0] = m_dsel;
	endtask

	// Steer mode drives wheels hard in one direction so they wrap
	task automatic drive_random(input game_t g, input logic steer);
		logic [31:0] r;
		player_array_t pl;
		logic vs;
		r = $urandom();
		pl = $urandom();
		// fire_d changes on about one cycle in four, so holds are common
		for (int p = 0; p < `MCR3_NUM_PLAYERS; p++) begin
			pl[p].fire_d = (r[2 * p +: 2] == 2'b00) ? ~m_prev_players[p].fire_d
				: m_prev_players[p].fire_d;
		end
		vs = steer ? ~m_prev_vsync : r[23];
		if (steer) begin
			pl[0].right = 1'b1;
			pl[0].left = 1'b0;
			pl[1].right = 1'b1;
			pl[1].left = 1'b0;
			pl[2].left = 1'b1;
			pl[2].right = 1'b0;
		end
		apply_inputs(g, pl, r[15:8], r[19:16], r[20], r[22:21], vs, r[31:24]);
	endtask

	// All seven outputs against one set of expected values
	task automatic compare_outputs(input logic [4:0][7:0] exp_ports,
		input sound_board_t exp_snd, input logic exp_mono);
		for (int i = 0; i < 5; i++) begin
			check_count++;
			if (dut_ports[i] !== exp_ports[i]) begin
				port_errors++;
				$display("error t=%0t in%0d expected %h got %h", $time, i, exp_ports[i],
					dut_ports[i]);
			end
		end
		check_count += 2;
		if (sound_board !== exp_snd) begin
			board_errors++;
			$display("error t=%0t sound_board expected %0d got %0d", $time, exp_snd, sound_board);
		end
		if (mono_board !== exp_mono) begin
			board_errors++;
			$display("error t=%0t mono_board expected %b got %b", $time, exp_mono, mono_board);
		end
	endtask

	task automatic check_outputs();
		logic [4:0][7:0] exp_ports;
		sound_board_t exp_snd;
		logic exp_mono;
		exp_ports = expected_ports();
		case (h_game[1])
			`MCR3_GAME_RAMPAGE, `MCR3_GAME_POWERDRV: exp_snd = SND_SG;
			`MCR3_GAME_DEMODERB: exp_snd = SND_TCS;
			default: exp_snd = SND_SSB;
		endcase
		exp_mono = !(h_game[1] == `MCR3_GAME_TIMBER || h_game[1] == `MCR3_GAME_TAPPER);
		compare_outputs(exp_ports, exp_snd, exp_mono);
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [31:0] r;
		void'($urandom(61682));
		clk_sys = 1'b0;
		reset <= 1'b1;
		apply_inputs(7'd1, '0, '0, 4'h0, 1'b0, 2'b00, 1'b0, 8'h00);
		m_gear = '0;
		m_wheel = '0;
		m_dsel = 1'b0;
		for (int i = 0; i < 4; i++) begin
			h_game[i] = 7'd1;
			h_dip[i] = '0;
			h_service[i] = 1'b0;
			h_snd[i] = '0;
			h_players[i] = '0;
			h_cabinet[i] = '0;
			h_gear[i] = '0;
			h_wheel[i] = '0;
			h_dsel[i] = 1'b0;
		end
		check_count = 0;
		port_errors = 0;
		board_errors = 0;
		// Direct inputs that would reach the ports if reset were ignored
		game <= `MCR3_GAME_POWERDRV;
		dip <= 4'hF;
		service <= 1'b1;
		snd_stat <= 2'b11;
		@(posedge clk_sys);
		game <= `MCR3_GAME_TAPPER;
		@(negedge clk_sys);
		compare_outputs('1, SND_SSB, 1'b1);
		@(posedge clk_sys);
		reset <= 1'b0;
		game <= 7'd1;
		dip <= 4'h0;
		service <= 1'b0;
		snd_stat <= 2'b00;
		@(negedge clk_sys);
		compare_outputs('1, SND_SSB, 1'b1);
		// Idle, Rampage, Timber/Tapper, Power Drive, Demolition Derby, unknown codes,
		// then Power Drive and Demolition Derby again
		for (int ph = 0; ph < NUM_PHASES; ph++) begin
			for (int c = 0; c < PHASE_CYCLES; c++) begin
				@(posedge clk_sys);
				r = $urandom();
				case (ph)
					0: apply_inputs(7'd1, '0, '0, 4'h0, 1'b0, 2'b00, 1'b0, 8'h00);
					1: drive_random(`MCR3_GAME_RAMPAGE, 1'b0);
					2: drive_random(r[0] ? `MCR3_GAME_TAPPER : `MCR3_GAME_TIMBER, 1'b0);
					3: drive_random(`MCR3_GAME_POWERDRV, 1'b0);
					4: drive_random(`MCR3_GAME_DEMODERB, 1'b1);
					5: drive_random(unknown_game(r), 1'b0);
					// Gears and wheels carried through the unknown codes show up here
					default: drive_random(r[0] ? `MCR3_GAME_POWERDRV : `MCR3_GAME_DEMODERB,
						1'b0);
				endcase
				@(negedge clk_sys);
				check_outputs();
			end
		end
		$display("checks %0d port errors %0d board errors %0d", check_count, port_errors,
			board_errors);
		if (port_errors == 0 && board_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired after %0d time units, the test did not finish", TIMEOUT);
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- rtl/mcr3_input_top.sv
`include "mcr3_consts.svh"

module mcr3_input_top
	import mcr3_input_pkg::*;
	(
	input logic clk_sys,
	input logic reset,
	input game_t game,
	input logic [3:0] dip,
	input logic service,
	input logic [1:0] snd_stat,
	input logic vsync,
	input player_array_t players,
	input cabinet_ctrl_t cabinet,
	input logic [7:0] cpu_out6,
	output logic [`MCR3_PORT_W-1:0] in0,
	output logic [`MCR3_PORT_W-1:0] in1,
	output logic [`MCR3_PORT_W-1:0] in2,
	output logic [`MCR3_PORT_W-1:0] in3,
	output logic [`MCR3_PORT_W-1:0] in4,
	output sound_board_t sound_board,
	output logic mono_board
);

	player_ctrl_if sampled_if ();
	player_ctrl_if staged_if ();
	cabinet_state_t state;

	// ==============================
	// Input sampling
	// ==============================

	ctrl_sampler #(.T(player_array_t)) u_player_sampler (
		.clk_sys (clk_sys),
		.reset   (reset),
		.d       (players),
		.q       (sampled_if.players),
		.rise    (sampled_if.player_rise)
	);

	ctrl_sampler #(.T(cabinet_ctrl_t)) u_cabinet_sampler (
		.clk_sys (clk_sys),
		.reset   (reset),
		.d       (cabinet),
		.q       (sampled_if.cabinet),
		.rise    (sampled_if.cabinet_rise)
	);

	// Only the frame edge is needed from vsync
	ctrl_sampler #(.T(logic)) u_vsync_sampler (
		.clk_sys (clk_sys),
		.reset   (reset),
		.d       (vsync),
		.q       (),
		.rise    (sampled_if.vsync_rise)
	);

	cabinet_state u_cabinet_state (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_out6 (cpu_out6),
		.sampled  (sampled_if.sink),
		.staged   (staged_if.source),
		.state    (state)
	);

	input_port_map u_port_map (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.game        (game),
		.dip         (dip),
		.service     (service),
		.snd_stat    (snd_stat),
		.staged      (staged_if.sink),
		.state       (state),
		.in0         (in0),
		.in1         (in1),
		.in2         (in2),
		.in3         (in3),
		.in4         (in4),
		.sound_board (sound_board),
		.mono_board  (mono_board)
	);

endmodule

//--- rtl/input_port_map.sv
`include "mcr3_consts.svh"

module input_port_map
	import mcr3_input_pkg::*;
	(
	input logic clk_sys,
	input logic reset,
	input game_t game,
	input logic [3:0] dip,
	input logic service,
	input logic [1:0] snd_stat,
	player_ctrl_if.sink staged,
	input cabinet_state_t state,
	output logic [`MCR3_PORT_W-1:0] in0,
	output logic [`MCR3_PORT_W-1:0] in1,
	output logic [`MCR3_PORT_W-1:0] in2,
	output logic [`MCR3_PORT_W-1:0] in3,
	output logic [`MCR3_PORT_W-1:0] in4,
	output sound_board_t sound_board,
	output logic mono_board
);

	// Active-high port words, inverted on the way out
	logic [4:0][`MCR3_PORT_W-1:0] word;
	sound_board_t snd_next;
	logic mono_next;

	player_ctrl_t p1;
	player_ctrl_t p2;
	player_ctrl_t p3;
	player_ctrl_t p4;
	cabinet_ctrl_t cab;

	assign p1 = staged.players[0];
	assign p2 = staged.players[1];
	assign p3 = staged.players[2];
	assign p4 = staged.players[3];
	assign cab = staged.cabinet;

	// ==============================
	// Per-game port assembly
	// ==============================

	always_comb begin
		word = '0;
		snd_next = SND_SSB;
		mono_next = 1'b1;
		case (game)
			`MCR3_GAME_RAMPAGE: begin
				snd_next = SND_SG;
				word[0] = {2'b00, service, 3'b000, cab.coin2, cab.coin1};
				word[1] = {2'b00, p1.fire_b, p1.fire_a, p1.left, p1.down, p1.right, p1.up};
				word[2] = {2'b00, p2.fire_b, p2.fire_a, p2.left, p2.down, p2.right, p2.up};
				word[3] = {dip[3], 4'b0000, dip[2], dip[1:0]};
				word[4] = {2'b00, p3.fire_b, p3.fire_a, p3.left, p3.down, p3.right, p3.up};
			end
			`MCR3_GAME_POWERDRV: begin
				snd_next = SND_SG;
				word[0] = {2'b00, service, 2'b00, cab.coin3, cab.coin2, cab.coin1};
				word[1] = {p2.fire_b, p2.fire_a, state.gear[1], p2.fire_c,
					p1.fire_b, p1.fire_a, state.gear[0], p1.fire_c};
				word[2] = {snd_stat[0], 3'b000, p3.fire_b, p3.fire_a, state.gear[2], p3.fire_c};
				word[3] = {dip[3], dip[2], dip[1:0], 4'b0000};
			end
			`MCR3_GAME_DEMODERB: begin
				snd_next = SND_TCS;
				word[0] = {2'b00, service, 1'b0, cab.start2, cab.start1, cab.coin2, cab.coin1};
				// CPU picks the front or rear wheel pair
				if (state.dderby_sel) begin
					word[1] = {state.wheel[2], p1.fire_b, p1.fire_a};
					word[2] = {state.wheel[3], p2.fire_b, p2.fire_a};
				end else begin
					word[1] = {state.wheel[0], p1.fire_b, p1.fire_a};
					word[2] = {state.wheel[1], p2.fire_b, p2.fire_a};
				end
				word[3] = {4'b0000, dip};
				word[4] = {p4.fire_b, p4.fire_a, p3.fire_b, p3.fire_a,
					cab.start4, cab.start3, cab.coin4, cab.coin3};
			end
			`MCR3_GAME_TIMBER, `MCR3_GAME_TAPPER: begin
				snd_next = SND_SSB;
				mono_next = 1'b0;
				word[0] = {service, 3'b000, cab.start2, cab.start1, cab.coin2, cab.coin1};
				word[1] = {2'b00, p1.fire_b, p1.fire_a, p1.up, p1.down, p1.left, p1.right};
				word[2] = {2'b00, p2.fire_b, p2.fire_a, p2.up, p2.down, p2.left, p2.right};
				word[3] = {1'b0, dip[1], 3'b000, dip[2], 2'b00};
			end
			// Unknown game, nothing pressed on any port
			default: begin
			end
		endcase
	end

	// ==============================
	// Output register
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in0 <= '1;
			in1 <= '1;
			in2 <= '1;
			in3 <= '1;
			in4 <= '1;
			sound_board <= SND_SSB;
			mono_board <= 1'b1;
		end else begin
			in0 <= ~word[0];
			in1 <= ~word[1];
			in2 <= ~word[2];
			in3 <= ~word[3];
			in4 <= ~word[4];
			sound_board <= snd_next;
			mono_board <= mono_next;
		end
	end

endmodule

//--- rtl/cabinet_state.sv
`include "mcr3_consts.svh"

module cabinet_state
	import mcr3_input_pkg::*;
	(
	input logic clk_sys,
	input logic reset,
	input logic [7:0] cpu_out6,
	player_ctrl_if.sink sampled,
	player_ctrl_if.source staged,
	output cabinet_state_t state
);

	logic [2:0] gear;
	logic [`MCR3_NUM_PLAYERS-1:0][`MCR3_WHEEL_W-1:0] wheel_pos;
	logic dderby_sel;

	// ==============================
	// Demolition Derby wheels
	// ==============================

	for (genvar p = 0; p < `MCR3_NUM_PLAYERS; p++) begin : g_wheel
		wheel_spinner u_spinner (
			.clk_sys    (clk_sys),
			.reset      (reset),
			.vsync_rise (sampled.vsync_rise),
			.left       (sampled.players[p].left),
			.right      (sampled.players[p].right),
			.position   (wheel_pos[p])
		);
	end

	// ==============================
	// Power Drive gears
	// ==============================

	// Each press of fire_d flips the shifter of players 1 to 3
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gear <= '0;
		end else begin
			for (int n = 0; n < 3; n++) begin
				if (sampled.player_rise[n].fire_d) begin
					gear[n] <= ~gear[n];
				end
			end
		end
	end

	// Wheel pair select written by the CPU on port 6
	// Bit 7 wins over bit 6
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dderby_sel <= 1'b0;
		end else if (cpu_out6[7]) begin
			dderby_sel <= 1'b0;
		end else if (cpu_out6[6]) begin
			dderby_sel <= 1'b1;
		end
	end

	assign state.gear = gear;
	assign state.wheel = wheel_pos;
	assign state.dderby_sel = dderby_sel;

	// ==============================
	// Alignment stage
	// ==============================

	// Held controls get one register so they line up with the derived state
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			staged.players <= '0;
			staged.player_rise <= '0;
			staged.cabinet <= '0;
			staged.cabinet_rise <= '0;
			staged.vsync_rise <= 1'b0;
		end else begin
			staged.players <= sampled.players;
			staged.player_rise <= sampled.player_rise;
			staged.cabinet <= sampled.cabinet;
			staged.cabinet_rise <= sampled.cabinet_rise;
			staged.vsync_rise <= sampled.vsync_rise;
		end
	end

endmodule

//--- rtl/wheel_spinner.sv
`include "mcr3_consts.svh"

module wheel_spinner
	import mcr3_input_pkg::*;
	(
	input logic clk_sys,
	input logic reset,
	input logic vsync_rise,
	input logic left,
	input logic right,
	output logic [`MCR3_WHEEL_W-1:0] position
);

	// One step per frame, both directions held means no motion
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			position <= '0;
		end else if (vsync_rise) begin
			if (right && !left) begin
				position <= position + 1'b1;
			end else if (left && !right) begin
				position <= position - 1'b1;
			end
		end
	end

endmodule

//--- rtl/ctrl_sampler.sv
module ctrl_sampler
	import mcr3_input_pkg::*;
	#(
	parameter type T = logic
	) (
	input logic clk_sys,
	input logic reset,
	input T d,
	output T q,
	output T rise
);

	// Value of q one clock earlier
	T q_prev;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			q <= '0;
			q_prev <= '0;
		end else begin
			q <= d;
			q_prev <= q;
		end
	end

	// High for one cycle on each 0 to 1 change of a bit
	assign rise = T'(q & ~q_prev);

endmodule

//--- rtl/player_ctrl_if.sv
interface player_ctrl_if
	import mcr3_input_pkg::*;
	();

	// Held levels
	player_array_t players;
	cabinet_ctrl_t cabinet;

	// One-cycle rising edge pulses
	player_array_t player_rise;
	cabinet_ctrl_t cabinet_rise;
	logic vsync_rise;

	modport source (
		output players,
		output player_rise,
		output cabinet,
		output cabinet_rise,
		output vsync_rise
	);

	modport sink (
		input players,
		input player_rise,
		input cabinet,
		input cabinet_rise,
		input vsync_rise
	);

endinterface

//--- rtl/mcr3_input_pkg.sv
`include "mcr3_consts.svh"

package mcr3_input_pkg;

	// ==============================
	// Board and game selection
	// ==============================

	typedef logic [`MCR3_GAME_W-1:0] game_t;

	// Sound board fitted to the game
	typedef enum logic [1:0] {
		SND_SSB = 2'd0,
		SND_TCS = 2'd1,
		SND_SG  = 2'd2
	} sound_board_t;

	// ==============================
	// Controls
	// ==============================

	// One player, active high, up is the MSB
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
	} player_ctrl_t;

	// Index 0 is player 1
	typedef player_ctrl_t [`MCR3_NUM_PLAYERS-1:0] player_array_t;

	// Coin and start buttons, active high
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic coin3;
		logic coin4;
		logic start1;
		logic start2;
		logic start3;
		logic start4;
	} cabinet_ctrl_t;

	// Derived cabinet state, wheel index 0 is wheel 1
	typedef struct packed {
		logic [2:0] gear;
		logic [`MCR3_NUM_PLAYERS-1:0][`MCR3_WHEEL_W-1:0] wheel;
		logic dderby_sel;
	} cabinet_state_t;

endpackage

//--- rtl/mcr3_consts.svh
`ifndef MCR3_CONSTS_SVH
`define MCR3_CONSTS_SVH

// ==============================
// Widths
// ==============================

// One CPU input port
`define MCR3_PORT_W 8

// Cabinet player count
`define MCR3_NUM_PLAYERS 4

// Spinner position, wraps modulo 64
`define MCR3_WHEEL_W 6

// Game select code
`define MCR3_GAME_W 7

// ==============================
// Game codes
// ==============================

`define MCR3_GAME_RAMPAGE 7'd0
`define MCR3_GAME_POWERDRV 7'd2
`define MCR3_GAME_DEMODERB 7'd4
`define MCR3_GAME_TIMBER 7'd6
`define MCR3_GAME_TAPPER 7'd7

`endif
